//--- design/conv_consts.svh
// shared constants of the binary 3x3 convolution engine, included by the rtl and the testbench
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// memory port widths
`define CONV_ADDR_W 12
`define CONV_WORD_W 16

// column index within one image row, rows are at most 16 wide
`define CONV_COL_W 4

// kernel side, the kernel is always square
`define CONV_K 3

// word read in place of a row count that ends the stream
`define CONV_END_MARKER 16'h00FF

// kernel word location in the weight memory
`define CONV_WEIGHT_ADDR 12'h001

// disagreement count at which a result bit goes to 0
`define CONV_MAJORITY 5

`endif

//--- design/conv_pkg.sv
// shared types of the convolution engine, imported by the rtl modules
`include "conv_consts.svh"

package conv_pkg;

	// memory address and data
	typedef logic [`CONV_ADDR_W-1:0] addr_t;
	typedef logic [`CONV_WORD_W-1:0] word_t;

	// column position inside a row
	typedef logic [`CONV_COL_W-1:0] col_t;

	// kernel bits, bit 3i+c is row i column c
	typedef logic [`CONV_K*`CONV_K-1:0] kernel_t;

	// controller states
	typedef enum logic [3:0] {
		idle,
		read_kernel,
		read_rows,
		read_cols,
		load_row0,
		load_row1,
		load_row2,
		sweep,
		next_row,
		finish
	} ctrl_state_t;

endpackage

//--- design/conv_ctrl.sv
// controller of the convolution engine that sequences header, kernel and row reads and sweeps columns
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_ctrl (
	input  logic             clk,
	input  logic             reset_b,
	input  logic             run,
	input  conv_pkg::word_t  input_read_data,
	input  logic             pipe_empty,
	output logic             busy,
	output conv_pkg::addr_t  input_read_address,
	output conv_pkg::addr_t  weight_read_address,
	output logic             load_kernel,
	output logic             shift_row,
	output conv_pkg::col_t   col,
	output logic             pix_valid,
	output logic             tag_valid,
	output conv_pkg::col_t   tag_col,
	output logic             tag_last,
	output conv_pkg::addr_t  tag_addr
);
	import conv_pkg::*;

	ctrl_state_t state;
	// output rows still to sweep in this image
	logic [4:0] rows_left;
	// last column presented in a sweep
	col_t last_col;
	// running output address across images
	addr_t out_addr;
	// pipe_empty one cycle back
	logic pipe_empty_q;
	logic header_end;
	logic col_done;

	assign header_end = (input_read_data == `CONV_END_MARKER);
	assign col_done = (col == last_col);

	// kernel sits at a fixed address
	assign weight_read_address = `CONV_WEIGHT_ADDR;

	// a row word is on the input bus in these states
	assign shift_row = (state == load_row0) | (state == load_row1) |
		(state == load_row2) | (state == next_row);

	assign pix_valid = (state == sweep);
	// window complete once K columns have gone in
	assign tag_valid = pix_valid & (col >= col_t'(`CONV_K - 1));
	assign tag_col = col - col_t'(`CONV_K - 1);
	assign tag_last = pix_valid & col_done;
	assign tag_addr = out_addr;

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			state <= idle;
			busy <= 1'b0;
			input_read_address <= '0;
			out_addr <= '0;
			col <= '0;
			rows_left <= '0;
			last_col <= '0;
			load_kernel <= 1'b0;
			pipe_empty_q <= 1'b0;
		end else begin
			load_kernel <= 1'b0;
			pipe_empty_q <= pipe_empty;
			case (state)
				idle: begin
					// stream always starts at input address 0
					input_read_address <= '0;
					if (run) begin
						busy <= 1'b1;
						out_addr <= '0;
						state <= read_kernel;
					end
				end
				read_kernel: begin
					// kernel word arrives next cycle
					load_kernel <= 1'b1;
					input_read_address <= input_read_address + 1'b1;
					state <= read_rows;
				end
				read_rows: begin
					if (header_end) begin
						busy <= 1'b0;
						state <= idle;
					end else begin
						// R-2 output rows per image
						rows_left <= input_read_data[4:0] - 5'(`CONV_K - 1);
						input_read_address <= input_read_address + 1'b1;
						state <= read_cols;
					end
				end
				read_cols: begin
					last_col <= col_t'(input_read_data[4:0] - 5'd1);
					input_read_address <= input_read_address + 1'b1;
					state <= load_row0;
				end
				load_row0: begin
					input_read_address <= input_read_address + 1'b1;
					state <= load_row1;
				end
				load_row1: begin
					input_read_address <= input_read_address + 1'b1;
					state <= load_row2;
				end
				load_row2: begin
					// address now points at the next row or next header
					col <= '0;
					state <= sweep;
				end
				sweep: begin
					if (col_done) begin
						col <= '0;
						out_addr <= out_addr + 1'b1;
						if (rows_left == 5'd1) begin
							state <= finish;
						end else begin
							rows_left <= rows_left - 5'd1;
							state <= next_row;
						end
					end else begin
						col <= col + 1'b1;
					end
				end
				next_row: begin
					// new bottom row is shifted in this cycle
					input_read_address <= input_read_address + 1'b1;
					state <= sweep;
				end
				finish: begin
					// drained after two empty cycles in a row since some stages hold a tag unseen at the top
					if (pipe_empty & pipe_empty_q) begin
						// header word is already on the bus so the column count is fetched next
						input_read_address <= input_read_address + 1'b1;
						state <= read_rows;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

endmodule

//--- design/row_window.sv
// three-row image window of the convolution engine, feeds one column of bits per cycle to the array
`timescale 1ns/1ps
`include "conv_consts.svh"

module row_window (
	input  logic                clk,
	input  logic                reset_b,
	input  logic                shift_row,
	input  conv_pkg::word_t     new_row,
	input  conv_pkg::col_t      col,
	input  logic                pix_valid,
	output logic [`CONV_K-1:0]  pix_bits,
	output logic                pix_out_valid
);
	import conv_pkg::*;

	// rows[0] is the top row of the window
	word_t rows [`CONV_K];

	// upward shift, new row enters at the bottom
	always_ff @(posedge clk) begin
		if (shift_row) begin
			for (int i = 0; i < `CONV_K - 1; i++) begin
				rows[i] <= rows[i + 1];
			end
			rows[`CONV_K - 1] <= new_row;
		end
	end

	// bit i of the column comes from window row i
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			for (int i = 0; i < `CONV_K; i++) begin
				pix_bits[i] <= rows[i][col];
			end
		end
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			pix_out_valid <= 1'b0;
		end else begin
			pix_out_valid <= pix_valid;
		end
	end

endmodule

//--- design/conv_array.sv
// 3x3 systolic compare array, yields nine kernel mismatch bits per window with the window tag
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_array (
	input  logic                          clk,
	input  logic                          reset_b,
	input  logic                          load_kernel,
	input  conv_pkg::kernel_t             kernel,
	input  logic [`CONV_K-1:0]            pix_bits,
	input  logic                          pix_in_valid,
	input  logic                          tag_valid,
	input  conv_pkg::col_t                tag_col,
	input  logic                          tag_last,
	input  conv_pkg::addr_t               tag_addr,
	output logic [`CONV_K*`CONV_K-1:0]    mismatch,
	output logic                          mm_valid,
	output conv_pkg::col_t                mm_col,
	output logic                          mm_last,
	output conv_pkg::addr_t               mm_addr
);
	import conv_pkg::*;

	// window reg, shift, compare reg
	localparam int tag_depth = 3;

	kernel_t kernel_q;
	// win[i][c] is row i, column c of the current window
	logic [`CONV_K-1:0][`CONV_K-1:0] win;
	logic [tag_depth-1:0] tag_v;
	logic [tag_depth-1:0] tag_l;
	col_t tag_c [tag_depth];
	addr_t tag_a [tag_depth];

	always_ff @(posedge clk) begin
		if (load_kernel) begin
			kernel_q <= kernel;
		end
	end

	// data moves from the newest cell toward column 0
	always_ff @(posedge clk) begin
		if (pix_in_valid) begin
			for (int i = 0; i < `CONV_K; i++) begin
				win[i][`CONV_K - 1] <= pix_bits[i];
				for (int c = 0; c < `CONV_K - 1; c++) begin
					win[i][c] <= win[i][c + 1];
				end
			end
		end
	end

	// one xor per cell
	always_ff @(posedge clk) begin
		for (int i = 0; i < `CONV_K; i++) begin
			for (int c = 0; c < `CONV_K; c++) begin
				mismatch[`CONV_K*i + c] <= kernel_q[`CONV_K*i + c] ^ win[i][c];
			end
		end
	end

	// tag travels alongside the data
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			tag_v <= '0;
		end else begin
			tag_v <= {tag_v[tag_depth-2:0], tag_valid};
		end
	end

	always_ff @(posedge clk) begin
		tag_l <= {tag_l[tag_depth-2:0], tag_last};
		tag_c[0] <= tag_col;
		tag_a[0] <= tag_addr;
		for (int s = 1; s < tag_depth; s++) begin
			tag_c[s] <= tag_c[s - 1];
			tag_a[s] <= tag_a[s - 1];
		end
	end

	assign mm_valid = tag_v[tag_depth-1];
	assign mm_last = tag_l[tag_depth-1];
	assign mm_col = tag_c[tag_depth-1];
	assign mm_addr = tag_a[tag_depth-1];

endmodule

//--- design/majority_vote.sv
// two-stage full adder tree, turns nine mismatch bits into one majority result bit
`timescale 1ns/1ps
`include "conv_consts.svh"

module majority_vote (
	input  logic                        clk,
	input  logic                        reset_b,
	input  logic [`CONV_K*`CONV_K-1:0]  mismatch,
	input  logic                        mm_valid,
	input  conv_pkg::col_t              mm_col,
	input  logic                        mm_last,
	input  conv_pkg::addr_t             mm_addr,
	output logic                        result_bit,
	output logic                        res_valid,
	output conv_pkg::col_t              res_col,
	output logic                        res_last,
	output conv_pkg::addr_t             res_addr
);
	import conv_pkg::*;

	// stage 1, one adder per kernel row
	logic [`CONV_K-1:0] s1_sum;
	logic [`CONV_K-1:0] s1_carry;
	// stage 2 weights 1, 2, 2, 4
	logic s2_ones;
	logic s2_twos_a;
	logic s2_twos_b;
	logic s2_fours;
	logic [3:0] count;
	logic mid_valid;
	logic mid_last;
	col_t mid_col;
	addr_t mid_addr;

	// {carry, sum}
	function automatic logic [1:0] full_add(input logic a, input logic b, input logic cin);
		return {(a & b) | (a & cin) | (b & cin), a ^ b ^ cin};
	endfunction

	always_ff @(posedge clk) begin
		for (int i = 0; i < `CONV_K; i++) begin
			{s1_carry[i], s1_sum[i]} <= full_add(mismatch[`CONV_K*i],
				mismatch[`CONV_K*i + 1], mismatch[`CONV_K*i + 2]);
		end
		{s2_twos_a, s2_ones} <= full_add(s1_sum[0], s1_sum[1], s1_sum[2]);
		{s2_fours, s2_twos_b} <= full_add(s1_carry[0], s1_carry[1], s1_carry[2]);
	end

	// total disagreements, 0 to 9
	assign count = {3'b000, s2_ones} + {2'b00, s2_twos_a, 1'b0} +
		{2'b00, s2_twos_b, 1'b0} + {1'b0, s2_fours, 2'b00};
	assign result_bit = (count < `CONV_MAJORITY);

	// tag follows the two adder stages
	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			mid_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			mid_valid <= mm_valid;
			res_valid <= mid_valid;
		end
	end

	always_ff @(posedge clk) begin
		mid_last <= mm_last;
		mid_col <= mm_col;
		mid_addr <= mm_addr;
		res_last <= mid_last;
		res_col <= mid_col;
		res_addr <= mid_addr;
	end

endmodule

//--- design/row_packer.sv
// gathers result bits into one output word per output row and writes it to the output memory
`timescale 1ns/1ps

module row_packer (
	input  logic             clk,
	input  logic             reset_b,
	input  logic             result_bit,
	input  logic             res_valid,
	input  conv_pkg::col_t   res_col,
	input  logic             res_last,
	input  conv_pkg::addr_t  res_addr,
	output conv_pkg::addr_t  output_write_address,
	output conv_pkg::word_t  output_write_data,
	output logic             output_write_enable,
	output logic             pipe_empty
);
	import conv_pkg::*;

	// partial row, bits past C-3 never set
	word_t acc;
	word_t acc_next;
	// some bits of a row received, write still to come
	logic holding;

	always_comb begin
		acc_next = acc;
		acc_next[res_col] = result_bit;
	end

	always_ff @(posedge clk or negedge reset_b) begin
		if (!reset_b) begin
			acc <= '0;
			holding <= 1'b0;
			output_write_enable <= 1'b0;
		end else begin
			output_write_enable <= res_valid & res_last;
			if (res_valid) begin
				if (res_last) begin
					// clear for the next row
					acc <= '0;
					holding <= 1'b0;
				end else begin
					acc <= acc_next;
					holding <= 1'b1;
				end
			end
		end
	end

	// word and address for the write one cycle after the last bit
	always_ff @(posedge clk) begin
		if (res_valid & res_last) begin
			output_write_data <= acc_next;
			output_write_address <= res_addr;
		end
	end

	assign pipe_empty = ~holding & ~output_write_enable;

endmodule

//--- design/conv_top.sv
// top of the binary 3x3 convolution engine, connects controller and datapath to the three memories
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_top (
	input  logic             clk,
	input  logic             reset_b,
	input  logic             run,
	output logic             busy,
	output conv_pkg::addr_t  input_read_address,
	input  conv_pkg::word_t  input_read_data,
	output conv_pkg::addr_t  weight_read_address,
	input  conv_pkg::word_t  weight_read_data,
	output conv_pkg::addr_t  output_write_address,
	output conv_pkg::word_t  output_write_data,
	output logic             output_write_enable
);
	import conv_pkg::*;

	logic load_kernel;
	logic shift_row;
	logic pix_valid;
	logic tag_valid;
	logic tag_last;
	logic pipe_empty;
	logic packer_empty;
	col_t col;
	col_t tag_col;
	addr_t tag_addr;
	kernel_t kernel;
	logic [`CONV_K-1:0] pix_bits;
	logic pix_out_valid;
	logic [`CONV_K*`CONV_K-1:0] mismatch;
	logic mm_valid;
	logic mm_last;
	col_t mm_col;
	addr_t mm_addr;
	logic result_bit;
	logic res_valid;
	logic res_last;
	col_t res_col;
	addr_t res_addr;

	// kernel bits are the low bits of the weight word
	assign kernel = weight_read_data[`CONV_K*`CONV_K-1:0];

	// nothing in flight in any visible stage, packer idle
	assign pipe_empty = ~(tag_valid | pix_out_valid | mm_valid | res_valid) & packer_empty;

	conv_ctrl u_ctrl (
		.clk                 (clk),
		.reset_b             (reset_b),
		.run                 (run),
		.input_read_data     (input_read_data),
		.pipe_empty          (pipe_empty),
		.busy                (busy),
		.input_read_address  (input_read_address),
		.weight_read_address (weight_read_address),
		.load_kernel         (load_kernel),
		.shift_row           (shift_row),
		.col                 (col),
		.pix_valid           (pix_valid),
		.tag_valid           (tag_valid),
		.tag_col             (tag_col),
		.tag_last            (tag_last),
		.tag_addr            (tag_addr)
	);

	// row words go straight from the input bus into the window
	row_window u_window (
		.clk           (clk),
		.reset_b       (reset_b),
		.shift_row     (shift_row),
		.new_row       (input_read_data),
		.col           (col),
		.pix_valid     (pix_valid),
		.pix_bits      (pix_bits),
		.pix_out_valid (pix_out_valid)
	);

	conv_array u_array (
		.clk          (clk),
		.reset_b      (reset_b),
		.load_kernel  (load_kernel),
		.kernel       (kernel),
		.pix_bits     (pix_bits),
		.pix_in_valid (pix_out_valid),
		.tag_valid    (tag_valid),
		.tag_col      (tag_col),
		.tag_last     (tag_last),
		.tag_addr     (tag_addr),
		.mismatch     (mismatch),
		.mm_valid     (mm_valid),
		.mm_col       (mm_col),
		.mm_last      (mm_last),
		.mm_addr      (mm_addr)
	);

	majority_vote u_vote (
		.clk        (clk),
		.reset_b    (reset_b),
		.mismatch   (mismatch),
		.mm_valid   (mm_valid),
		.mm_col     (mm_col),
		.mm_last    (mm_last),
		.mm_addr    (mm_addr),
		.result_bit (result_bit),
		.res_valid  (res_valid),
		.res_col    (res_col),
		.res_last   (res_last),
		.res_addr   (res_addr)
	);

	row_packer u_packer (
		.clk                  (clk),
		.reset_b              (reset_b),
		.result_bit           (result_bit),
		.res_valid            (res_valid),
		.res_col              (res_col),
		.res_last             (res_last),
		.res_addr             (res_addr),
		.output_write_address (output_write_address),
		.output_write_data    (output_write_data),
		.output_write_enable  (output_write_enable),
		.pipe_empty           (packer_empty)
	);

endmodule

//--- verif/conv_tb.sv
// testbench of the convolution engine that runs a table of kernels and images and checks each output row
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_tb;
	import conv_pkg::*;

	localparam int num_runs = 6;
	localparam int max_imgs = 3;
	localparam int mem_words = 1 << `CONV_ADDR_W;

	// one entry per run with kernel and image count, then rows, cols and seed offset per image
	// run 3 is a bare end marker
	logic [8:0] run_kernel [num_runs] = '{9'h000, 9'h1ff, 9'h0ba, 9'h000, 9'h145, 9'h093};
	int run_imgs [num_runs] = '{2, 2, 3, 0, 1, 2};
	int img_rows [num_runs][max_imgs] = '{'{5, 4, 0}, '{16, 3, 0}, '{6, 3, 8},
		'{0, 0, 0}, '{7, 0, 0}, '{9, 4, 0}};
	int img_cols [num_runs][max_imgs] = '{'{3, 9, 0}, '{16, 3, 0}, '{9, 16, 5},
		'{0, 0, 0}, '{12, 0, 0}, '{16, 9, 0}};
	int img_seed [num_runs][max_imgs] = '{'{1, 2, 0}, '{3, 4, 0}, '{5, 6, 7},
		'{0, 0, 0}, '{8, 0, 0}, '{9, 10, 0}};

	logic clk = 1'b0;
	logic reset_b;
	logic run;
	logic busy;
	addr_t input_read_address;
	word_t input_read_data;
	addr_t weight_read_address;
	word_t weight_read_data;
	addr_t output_write_address;
	word_t output_write_data;
	logic output_write_enable;

	// memory models
	word_t in_mem [mem_words];
	word_t wt_mem [mem_words];
	word_t out_mem [mem_words];
	// rows of the image being built for the reference model
	word_t cur_rows [16];
	word_t exp_words [$];
	addr_t wr_addrs [$];

	int cycles = 0;
	int cycle_limit = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int errors_before;
	int n_writes;

	conv_top DUT (
		.clk                  (clk),
		.reset_b              (reset_b),
		.run                  (run),
		.busy                 (busy),
		.input_read_address   (input_read_address),
		.input_read_data      (input_read_data),
		.weight_read_address  (weight_read_address),
		.weight_read_data     (weight_read_data),
		.output_write_address (output_write_address),
		.output_write_data    (output_write_data),
		.output_write_enable  (output_write_enable)
	);

	always #10 clk = ~clk;

	// one cycle read latency on both read memories
	always @(posedge clk) begin
		input_read_data <= in_mem[input_read_address];
		weight_read_data <= wt_mem[weight_read_address];
	end

	// output memory that also logs every write in order
	always @(posedge clk) begin
		if (output_write_enable) begin
			out_mem[output_write_address] <= output_write_data;
			wr_addrs.push_back(output_write_address);
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, busy never fell", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// 32 bit lcg step
	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// majority rule over the windows of output row r
	function automatic word_t ref_word(input logic [8:0] k, input int r, input int ncols);
		word_t w;
		int n;
		w = '0;
		for (int j = 0; j <= ncols - 3; j++) begin
			n = 0;
			for (int i = 0; i < 3; i++) begin
				for (int c = 0; c < 3; c++) begin
					if (k[3*i + c] != cur_rows[r + i][j + c]) begin
						n++;
					end
				end
			end
			w[j] = (n < `CONV_MAJORITY);
		end
		return w;
	endfunction

	// memories and expected words for one table entry
	task automatic load_run(input int ri);
		int addr;
		int nrows;
		int ncols;
		logic [31:0] s;
		word_t mask;
		exp_words.delete();
		wr_addrs.delete();
		for (int a = 0; a < mem_words; a++) begin
			in_mem[a] = {4'hc, 12'(a)};
			wt_mem[a] = {4'h3, 12'(a)};
			out_mem[a] = {4'he, 12'(a)};
		end
		wt_mem[`CONV_WEIGHT_ADDR] = {7'b0, run_kernel[ri]};
		addr = 0;
		for (int m = 0; m < run_imgs[ri]; m++) begin
			nrows = img_rows[ri][m];
			ncols = img_cols[ri][m];
			in_mem[addr] = word_t'(nrows);
			addr = addr + 1;
			in_mem[addr] = word_t'(ncols);
			addr = addr + 1;
			s = 32'd75872 + 32'(img_seed[ri][m]);
			// only the C columns of a row carry data
			mask = word_t'((32'd1 << ncols) - 32'd1);
			for (int r = 0; r < nrows; r++) begin
				s = lcg_step(s);
				cur_rows[r] = s[31:16] & mask;
				in_mem[addr] = cur_rows[r];
				addr = addr + 1;
			end
			for (int r = 0; r <= nrows - 3; r++) begin
				exp_words.push_back(ref_word(run_kernel[ri], r, ncols));
			end
		end
		in_mem[addr] = `CONV_END_MARKER;
	endtask

	initial begin
		reset_b = 1'b0;
		run = 1'b0;
		input_read_data = '0;
		weight_read_data = '0;
		// rows x (cols + 8) per image plus slack per run
		cycle_limit = 40;
		for (int ri = 0; ri < num_runs; ri++) begin
			cycle_limit = cycle_limit + 40;
			for (int m = 0; m < run_imgs[ri]; m++) begin
				cycle_limit = cycle_limit + img_rows[ri][m] * (img_cols[ri][m] + 8);
			end
		end
		repeat (3) @(posedge clk);
		reset_b <= 1'b1;
		@(negedge clk);

		// idle outputs after reset
		errors_before = errors;
		assert (busy === 1'b0) else begin
			$display("FAIL busy after reset: got %h expected %h", busy, 1'b0);
			errors++;
		end
		assert (output_write_enable === 1'b0) else begin
			$display("FAIL output_write_enable after reset: got %h expected %h",
				output_write_enable, 1'b0);
			errors++;
		end
		if (errors == errors_before) begin
			tests_passed++;
			$display("reset test passed");
		end else begin
			tests_failed++;
			$display("reset test failed");
		end

		for (int ri = 0; ri < num_runs; ri++) begin
			errors_before = errors;
			load_run(ri);
			@(posedge clk);
			run <= 1'b1;
			@(posedge clk);
			run <= 1'b0;
			@(negedge clk);
			assert (busy === 1'b1) else begin
				$display("FAIL busy after run %0d: got %h expected %h", ri, busy, 1'b1);
				errors++;
			end
			do begin
				@(negedge clk);
			end while (busy !== 1'b0);
			// no write may follow the fall of busy
			n_writes = wr_addrs.size();
			repeat (10) @(negedge clk);
			assert (wr_addrs.size() == n_writes) else begin
				$display("run %0d: writes continued after busy fell", ri);
				errors++;
			end
			assert (wr_addrs.size() == exp_words.size()) else begin
				$display("run %0d: %0d writes seen where %0d were expected",
					ri, wr_addrs.size(), exp_words.size());
				errors++;
			end
			for (int i = 0; i < wr_addrs.size(); i++) begin
				assert (wr_addrs[i] == addr_t'(i)) else begin
					$display("FAIL output_write_address write %0d: got %h expected %h",
						i, wr_addrs[i], addr_t'(i));
					errors++;
				end
			end
			for (int i = 0; i < exp_words.size(); i++) begin
				assert (out_mem[i] === exp_words[i]) else begin
					$display("FAIL output_write_data at %h: got %h expected %h",
						addr_t'(i), out_mem[i], exp_words[i]);
					errors++;
				end
			end
			if (errors == errors_before) begin
				tests_passed++;
				$display("run %0d passed, kernel %h, %0d words", ri, run_kernel[ri],
					exp_words.size());
			end else begin
				tests_failed++;
				$display("run %0d failed, kernel %h", ri, run_kernel[ri]);
			end
		end

		$display("%0d tests passed, %0d tests failed, %0d errors", tests_passed,
			tests_failed, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+design
design/conv_pkg.sv
design/conv_ctrl.sv
design/row_window.sv
design/conv_array.sv
design/majority_vote.sv
design/row_packer.sv
design/conv_top.sv
verif/conv_tb.sv

//--- Bender.yml
package:
  name: conv_engine

sources:
  - include_dirs:
      - design
    files:
      - design/conv_pkg.sv
      - design/conv_ctrl.sv
      - design/row_window.sv
      - design/conv_array.sv
      - design/majority_vote.sv
      - design/row_packer.sv
      - design/conv_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/conv_tb.sv
